//--- include/dlx_defines.svh
`ifndef DLX_DEFINES_SVH
`define DLX_DEFINES_SVH

// Machine word and register file size
`define DLX_XLEN   32
`define DLX_NREGS  32

// Instruction field positions
`define DLX_OP_HI     31
`define DLX_OP_LO     26
`define DLX_RS1_HI    25
`define DLX_RS1_LO    21
`define DLX_RS2_HI    20
`define DLX_RS2_LO    16
`define DLX_RD_HI     15
`define DLX_RD_LO     11
`define DLX_FUNCT_HI  5
`define DLX_FUNCT_LO  0
`define DLX_IMM_HI    15
`define DLX_IMM_LO    0
`define DLX_JOFF_HI   25
`define DLX_JOFF_LO   0

// All-zero word, an R-type ADD into r0
`define DLX_NOP  32'h0000_0000

`endif

//--- verilog/dlx_pkg.sv
`include "dlx_defines.svh"

package dlx_pkg;

    // Major opcodes of the kept instructions
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQZ  = 6'h04,
        OP_BNEZ  = 6'h05,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    // R-type function codes
    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_XOR = 6'h26,
        FN_SLT = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    // Operand source for the instruction in EX
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_EXMEM,
        FWD_MEMWB
    } fwd_sel_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_src_imm;
        logic    mem_rd;
        logic    mem_wr;
        logic    reg_wr;
        logic    branch;
        logic    branch_nz;
        logic    jump;
    } ctrl_t;

    ////////////////////////////////////////////////////////////
    // Stage registers

    typedef struct packed {
        logic [`DLX_XLEN-1:0] inc_pc;
        logic [`DLX_XLEN-1:0] instr;
        logic                 valid;
    } if_id_t;

    typedef struct packed {
        ctrl_t                ctrl;
        logic [`DLX_XLEN-1:0] inc_pc;
        logic [`DLX_XLEN-1:0] bus_a;
        logic [`DLX_XLEN-1:0] bus_b;
        logic [`DLX_XLEN-1:0] imm32;
        logic [4:0]           rs1;
        logic [4:0]           rs2;
        logic [4:0]           rd;
        logic                 valid;
    } id_ex_t;

    typedef struct packed {
        ctrl_t                ctrl;
        logic [`DLX_XLEN-1:0] inc_pc;
        logic [`DLX_XLEN-1:0] imm32;
        logic [`DLX_XLEN-1:0] alu_res;
        logic [`DLX_XLEN-1:0] store_data;
        logic                 bus_a_zero;
        logic [4:0]           rd;
        logic                 valid;
    } ex_mem_t;

    typedef struct packed {
        logic                 reg_wr;
        logic                 mem_rd;
        logic [`DLX_XLEN-1:0] alu_res;
        logic [`DLX_XLEN-1:0] mem_rd_data;
        logic [4:0]           rd;
        logic                 valid;
    } mem_wb_t;

endpackage

//--- verilog/dlx_decode.sv
`timescale 1ns/1ps
`include "dlx_defines.svh"

module dlx_decode import dlx_pkg::*; (
    input  logic [`DLX_XLEN-1:0] instr,
    output ctrl_t                ctrl,
    output logic [4:0]           rs1,
    output logic [4:0]           rs2,
    output logic [4:0]           rd,
    output logic [`DLX_XLEN-1:0] imm32
);

    opcode_e              opcode;
    funct_e               funct;
    logic [`DLX_XLEN-1:0] imm_i;
    logic [`DLX_XLEN-1:0] imm_j;

    assign opcode = opcode_e'(instr[`DLX_OP_HI:`DLX_OP_LO]);
    assign funct  = funct_e'(instr[`DLX_FUNCT_HI:`DLX_FUNCT_LO]);
    assign rs1    = instr[`DLX_RS1_HI:`DLX_RS1_LO];
    assign rs2    = instr[`DLX_RS2_HI:`DLX_RS2_LO];

    // Sign extension of the 16 bit immediate and the 26 bit jump offset
    assign imm_i = {{(`DLX_XLEN-1-`DLX_IMM_HI){instr[`DLX_IMM_HI]}},
                    instr[`DLX_IMM_HI:`DLX_IMM_LO]};
    assign imm_j = {{(`DLX_XLEN-1-`DLX_JOFF_HI){instr[`DLX_JOFF_HI]}},
                    instr[`DLX_JOFF_HI:`DLX_JOFF_LO]};

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ALU_ADD;
        imm32       = imm_i;
        // I-type writes the rs2 field
        rd          = instr[`DLX_RS2_HI:`DLX_RS2_LO];
        case (opcode)
            OP_RTYPE: begin
                rd          = instr[`DLX_RD_HI:`DLX_RD_LO];
                ctrl.reg_wr = 1'b1;
                case (funct)
                    FN_ADD:  ctrl.alu_op = ALU_ADD;
                    FN_SUB:  ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_XOR:  ctrl.alu_op = ALU_XOR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    // NOP word lands here as an add into r0
                    default: ctrl.alu_op = ALU_ADD;
                endcase
            end
            OP_ADDI: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_wr      = 1'b1;
            end
            OP_LW: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_rd      = 1'b1;
                ctrl.reg_wr      = 1'b1;
            end
            OP_SW: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_wr      = 1'b1;
            end
            OP_BEQZ: ctrl.branch = 1'b1;
            OP_BNEZ: begin
                ctrl.branch    = 1'b1;
                ctrl.branch_nz = 1'b1;
            end
            OP_J: begin
                ctrl.jump = 1'b1;
                imm32     = imm_j;
            end
            // Unknown opcode stays a harmless no-op
            default: ctrl = '0;
        endcase
    end

endmodule

//--- verilog/dlx_hazard.sv
`timescale 1ns/1ps

module dlx_hazard import dlx_pkg::*; (
    input  logic [4:0] id_rs1,
    input  logic [4:0] id_rs2,
    input  logic [4:0] ex_rs1,
    input  logic [4:0] ex_rs2,
    input  logic [4:0] ex_rd,
    input  logic       ex_mem_rd,
    input  logic       ex_valid,
    input  logic [4:0] mem_rd,
    input  logic       mem_reg_wr,
    input  logic [4:0] wb_rd,
    input  logic       wb_reg_wr,
    input  logic       take_branch,
    output fwd_sel_e   fwd_a,
    output fwd_sel_e   fwd_b,
    output logic       pc_enable,
    output logic       if_id_hold,
    output logic       id_ex_bubble,
    output logic       flush
);

    logic load_use;

    // Younger EX/MEM result wins over MEM/WB
    function automatic fwd_sel_e pick_src(input logic [4:0] src);
        fwd_sel_e sel;
        sel = FWD_REG;
        if (src != 5'd0) begin
            if (mem_reg_wr && (mem_rd == src)) begin
                sel = FWD_EXMEM;
            end else if (wb_reg_wr && (wb_rd == src)) begin
                sel = FWD_MEMWB;
            end
        end
        return sel;
    endfunction

    always_comb begin
        fwd_a = pick_src(ex_rs1);
        fwd_b = pick_src(ex_rs2);
    end

    // Load in EX feeding the instruction in ID
    assign load_use = ex_valid && ex_mem_rd && (ex_rd != 5'd0) &&
                      ((ex_rd == id_rs1) || (ex_rd == id_rs2));

    // Branch in MEM kills the stall along with everything younger
    assign flush        = take_branch;
    assign pc_enable    = !load_use || take_branch;
    assign if_id_hold   = !load_use || take_branch;
    assign id_ex_bubble = load_use && !take_branch;

endmodule

//--- verilog/dlx_execute.sv
`timescale 1ns/1ps
`include "dlx_defines.svh"

module dlx_execute import dlx_pkg::*; (
    input  logic [`DLX_XLEN-1:0] op_a,
    input  logic [`DLX_XLEN-1:0] op_b,
    input  logic [`DLX_XLEN-1:0] imm32,
    input  ctrl_t                ctrl,
    output logic [`DLX_XLEN-1:0] alu_res,
    output logic                 a_zero
);

    logic [`DLX_XLEN-1:0] src_b;

    // Immediate forms take imm32 as second operand
    assign src_b = ctrl.alu_src_imm ? imm32 : op_b;

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD: alu_res = op_a + src_b;
            ALU_SUB: alu_res = op_a - src_b;
            ALU_AND: alu_res = op_a & src_b;
            ALU_OR:  alu_res = op_a | src_b;
            ALU_XOR: alu_res = op_a ^ src_b;
            ALU_SLT: begin
                alu_res = {{(`DLX_XLEN-1){1'b0}}, ($signed(op_a) < $signed(src_b))};
            end
            default: alu_res = op_a + src_b;
        endcase
    end

    // Zero test on rs1 for BEQZ and BNEZ
    assign a_zero = (op_a == '0);

endmodule

//--- verilog/dlx_regfile.sv
`timescale 1ns/1ps
`include "dlx_defines.svh"

module dlx_regfile (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [4:0]           rs1,
    input  logic [4:0]           rs2,
    input  logic [4:0]           wr_rd,
    input  logic                 wr_en,
    input  logic [`DLX_XLEN-1:0] wr_data,
    output logic [`DLX_XLEN-1:0] bus_a,
    output logic [`DLX_XLEN-1:0] bus_b
);

    logic [`DLX_XLEN-1:0] regs [`DLX_NREGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `DLX_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_rd != 5'd0)) begin
            regs[wr_rd] <= wr_data;
        end
    end

    // Write-first so ID sees the value retiring this cycle
    function automatic logic [`DLX_XLEN-1:0] read_port(input logic [4:0] idx);
        logic [`DLX_XLEN-1:0] val;
        if (idx == 5'd0) begin
            val = '0;
        end else if (wr_en && (wr_rd == idx)) begin
            val = wr_data;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_comb begin
        bus_a = read_port(rs1);
        bus_b = read_port(rs2);
    end

endmodule

//--- verilog/dlx_pipeline.sv
`timescale 1ns/1ps
`include "dlx_defines.svh"

module dlx_pipeline import dlx_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`DLX_XLEN-1:0] init_pc,
    output logic [`DLX_XLEN-1:0] i_addr,
    input  logic [`DLX_XLEN-1:0] instruction,
    output logic [4:0]           rs1,
    output logic [4:0]           rs2,
    input  logic [`DLX_XLEN-1:0] bus_a,
    input  logic [`DLX_XLEN-1:0] bus_b,
    output logic [`DLX_XLEN-1:0] mem_addr,
    output logic [`DLX_XLEN-1:0] mem_wr_data,
    output logic                 mem_wr,
    input  logic [`DLX_XLEN-1:0] mem_rd_data,
    output logic                 reg_wr,
    output logic [4:0]           rd,
    output logic [`DLX_XLEN-1:0] reg_wr_data
);

    logic [`DLX_XLEN-1:0] pc;
    logic [`DLX_XLEN-1:0] inc_pc;
    logic [`DLX_XLEN-1:0] target;
    if_id_t               if_id;
    id_ex_t               id_ex;
    ex_mem_t              ex_mem;
    mem_wb_t              mem_wb;
    ctrl_t                id_ctrl;
    logic [4:0]           id_rd;
    logic [`DLX_XLEN-1:0] id_imm32;
    fwd_sel_e             fwd_a;
    fwd_sel_e             fwd_b;
    logic                 pc_enable;
    logic                 if_id_hold;
    logic                 id_ex_bubble;
    logic                 flush;
    logic                 take_branch;
    logic [`DLX_XLEN-1:0] op_a;
    logic [`DLX_XLEN-1:0] op_b;
    logic [`DLX_XLEN-1:0] alu_res;
    logic                 a_zero;
    logic [`DLX_XLEN-1:0] wb_data;

    ////////////////////////////////////////////////////////////
    // IF

    assign i_addr = pc;
    assign inc_pc = pc + `DLX_XLEN'd4;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= init_pc;
        end else if (pc_enable) begin
            pc <= take_branch ? target : inc_pc;
        end
    end

    // Flushed slot carries a NOP so decode stays quiet
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            if_id <= '{inc_pc: '0, instr: `DLX_NOP, valid: 1'b0};
        end else if (if_id_hold) begin
            if_id <= '{inc_pc: inc_pc, instr: instruction, valid: 1'b1};
        end
    end

    ////////////////////////////////////////////////////////////
    // ID

    dlx_decode i_dlx_decode (
        .instr (if_id.instr),
        .ctrl  (id_ctrl),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd    (id_rd),
        .imm32 (id_imm32)
    );

    dlx_hazard i_dlx_hazard (
        .id_rs1       (rs1),
        .id_rs2       (rs2),
        .ex_rs1       (id_ex.rs1),
        .ex_rs2       (id_ex.rs2),
        .ex_rd        (id_ex.rd),
        .ex_mem_rd    (id_ex.ctrl.mem_rd),
        .ex_valid     (id_ex.valid),
        .mem_rd       (ex_mem.rd),
        .mem_reg_wr   (ex_mem.valid && ex_mem.ctrl.reg_wr),
        .wb_rd        (mem_wb.rd),
        .wb_reg_wr    (reg_wr),
        .take_branch  (take_branch),
        .fwd_a        (fwd_a),
        .fwd_b        (fwd_b),
        .pc_enable    (pc_enable),
        .if_id_hold   (if_id_hold),
        .id_ex_bubble (id_ex_bubble),
        .flush        (flush)
    );

    always_ff @(posedge clk) begin
        if (rst || flush || id_ex_bubble) begin
            id_ex.valid <= 1'b0;
        end else begin
            id_ex <= '{ctrl: id_ctrl, inc_pc: if_id.inc_pc, bus_a: bus_a, bus_b: bus_b,
                       imm32: id_imm32, rs1: rs1, rs2: rs2, rd: id_rd,
                       valid: if_id.valid};
        end
    end

    ////////////////////////////////////////////////////////////
    // EX

    // Forwarding muxes
    always_comb begin
        case (fwd_a)
            FWD_EXMEM: op_a = ex_mem.alu_res;
            FWD_MEMWB: op_a = wb_data;
            default:   op_a = id_ex.bus_a;
        endcase
        case (fwd_b)
            FWD_EXMEM: op_b = ex_mem.alu_res;
            FWD_MEMWB: op_b = wb_data;
            default:   op_b = id_ex.bus_b;
        endcase
    end

    dlx_execute i_dlx_execute (
        .op_a    (op_a),
        .op_b    (op_b),
        .imm32   (id_ex.imm32),
        .ctrl    (id_ex.ctrl),
        .alu_res (alu_res),
        .a_zero  (a_zero)
    );

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            ex_mem.valid <= 1'b0;
        end else begin
            ex_mem <= '{ctrl: id_ex.ctrl, inc_pc: id_ex.inc_pc, imm32: id_ex.imm32,
                        alu_res: alu_res, store_data: op_b, bus_a_zero: a_zero,
                        rd: id_ex.rd, valid: id_ex.valid};
        end
    end

    ////////////////////////////////////////////////////////////
    // MEM

    // BEQZ on zero, BNEZ on nonzero, J always
    assign take_branch = ex_mem.valid &&
                         (ex_mem.ctrl.jump ||
                          (ex_mem.ctrl.branch && (ex_mem.bus_a_zero ^ ex_mem.ctrl.branch_nz)));
    assign target      = ex_mem.inc_pc + ex_mem.imm32;

    assign mem_addr    = ex_mem.alu_res;
    assign mem_wr_data = ex_mem.store_data;
    assign mem_wr      = ex_mem.valid && ex_mem.ctrl.mem_wr;

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wb.valid <= 1'b0;
        end else begin
            mem_wb <= '{reg_wr: ex_mem.ctrl.reg_wr, mem_rd: ex_mem.ctrl.mem_rd,
                        alu_res: ex_mem.alu_res, mem_rd_data: mem_rd_data,
                        rd: ex_mem.rd, valid: ex_mem.valid};
        end
    end

    ////////////////////////////////////////////////////////////
    // WB

    assign wb_data     = mem_wb.mem_rd ? mem_wb.mem_rd_data : mem_wb.alu_res;
    assign reg_wr_data = wb_data;
    assign rd          = mem_wb.rd;
    // r0 writes never reach the retire port
    assign reg_wr      = mem_wb.valid && mem_wb.reg_wr && (mem_wb.rd != 5'd0);

endmodule

//--- verilog/dlx_core.sv
`timescale 1ns/1ps
`include "dlx_defines.svh"

module dlx_core (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`DLX_XLEN-1:0] init_pc,
    output logic [`DLX_XLEN-1:0] i_addr,
    input  logic [`DLX_XLEN-1:0] instruction,
    output logic [`DLX_XLEN-1:0] mem_addr,
    output logic [`DLX_XLEN-1:0] mem_wr_data,
    output logic                 mem_wr,
    input  logic [`DLX_XLEN-1:0] mem_rd_data,
    output logic                 reg_wr,
    output logic [4:0]           rd,
    output logic [`DLX_XLEN-1:0] reg_wr_data
);

    // Register read ports between ID and the register file
    logic [4:0]           rs1;
    logic [4:0]           rs2;
    logic [`DLX_XLEN-1:0] bus_a;
    logic [`DLX_XLEN-1:0] bus_b;

    dlx_pipeline i_dlx_pipeline (
        .clk         (clk),
        .rst         (rst),
        .init_pc     (init_pc),
        .i_addr      (i_addr),
        .instruction (instruction),
        .rs1         (rs1),
        .rs2         (rs2),
        .bus_a       (bus_a),
        .bus_b       (bus_b),
        .mem_addr    (mem_addr),
        .mem_wr_data (mem_wr_data),
        .mem_wr      (mem_wr),
        .mem_rd_data (mem_rd_data),
        .reg_wr      (reg_wr),
        .rd          (rd),
        .reg_wr_data (reg_wr_data)
    );

    // Write port is the retire port
    dlx_regfile i_dlx_regfile (
        .clk     (clk),
        .rst     (rst),
        .rs1     (rs1),
        .rs2     (rs2),
        .wr_rd   (rd),
        .wr_en   (reg_wr),
        .wr_data (reg_wr_data),
        .bus_a   (bus_a),
        .bus_b   (bus_b)
    );

endmodule

//--- testbench/dlx_core_chk.sv
`timescale 1ns/1ps
`include "dlx_defines.svh"

module dlx_core_chk (
    input logic                 clk,
    input logic                 rst,
    input logic                 flush,
    input logic                 mem_wr,
    input logic                 reg_wr,
    input logic [4:0]           rs1,
    input logic [4:0]           rs2,
    input logic [`DLX_XLEN-1:0] bus_a,
    input logic [`DLX_XLEN-1:0] bus_b
);

    // Writes stay quiet while reset is held
    assert property (@(posedge clk) (rst && $past(rst)) |-> (!mem_wr && !reg_wr))
        else $error("write strobe active during reset");

    // Three cycles after a flush belong to discarded or branch entries
    assert property (@(posedge clk) disable iff (rst)
        ($past(flush, 1) || $past(flush, 2) || $past(flush, 3)) |-> (!mem_wr && !reg_wr))
        else $error("write from a flushed pipeline entry");

    // r0 reads zero even while an r0 write sits in WB
    assert property (@(posedge clk) disable iff (rst) (rs1 == 5'd0) |-> (bus_a == '0))
        else $error("nonzero value read from r0 on port a");

    assert property (@(posedge clk) disable iff (rst) (rs2 == 5'd0) |-> (bus_b == '0))
        else $error("nonzero value read from r0 on port b");

endmodule

bind dlx_pipeline dlx_core_chk i_dlx_core_chk (
    .clk    (clk),
    .rst    (rst),
    .flush  (flush),
    .mem_wr (mem_wr),
    .reg_wr (reg_wr),
    .rs1    (rs1),
    .rs2    (rs2),
    .bus_a  (bus_a),
    .bus_b  (bus_b)
);

//--- testbench/dlx_core_tb.sv
`timescale 1ns/1ps
`include "dlx_defines.svh"

module dlx_core_tb;

    ////////////////////////////////////////////////////////////
    // Golden file layout in words
    localparam int PROG_BASE   = 16;
    localparam int DATA_BASE   = 80;
    localparam int RETIRE_BASE = 112;
    localparam int STORE_BASE  = 176;

    logic                 clk;
    logic                 rst;
    logic [`DLX_XLEN-1:0] init_pc;
    logic [`DLX_XLEN-1:0] i_addr;
    logic [`DLX_XLEN-1:0] instruction;
    logic [`DLX_XLEN-1:0] mem_addr;
    logic [`DLX_XLEN-1:0] mem_wr_data;
    logic                 mem_wr;
    logic [`DLX_XLEN-1:0] mem_rd_data;
    logic                 reg_wr;
    logic [4:0]           rd;
    logic [`DLX_XLEN-1:0] reg_wr_data;

    logic [`DLX_XLEN-1:0] gold [256];
    logic [`DLX_XLEN-1:0] imem [256];
    logic [`DLX_XLEN-1:0] dmem [256];
    int n_prog;
    int n_data;
    int n_ret;
    int n_st;
    int ret_idx = 0;
    int st_idx  = 0;
    int errors  = 0;
    int cyc     = 0;

    dlx_core i_dlx_core (
        .clk         (clk),
        .rst         (rst),
        .init_pc     (init_pc),
        .i_addr      (i_addr),
        .instruction (instruction),
        .mem_addr    (mem_addr),
        .mem_wr_data (mem_wr_data),
        .mem_wr      (mem_wr),
        .mem_rd_data (mem_rd_data),
        .reg_wr      (reg_wr),
        .rd          (rd),
        .reg_wr_data (reg_wr_data)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Both memories answer within the cycle
    assign instruction = imem[i_addr[9:2]];
    assign mem_rd_data = dmem[mem_addr[9:2]];

    initial begin
        for (int i = 0; i < 256; i++) begin
            gold[i] = '0;
        end
        $readmemh("testbench/dlx_core_golden.txt", gold);
        n_prog = int'(gold[0]);
        n_data = int'(gold[1]);
        n_ret  = int'(gold[2]);
        n_st   = int'(gold[3]);
        // Unused words are ADDI r0 tagged with their own index
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'h2000_0000 | 32'(i);
            dmem[i] <= 32'ha5a5_0000 ^ (32'(i) * 32'h0001_0101);
        end
        for (int i = 0; i < n_prog; i++) begin
            imem[i] = gold[PROG_BASE+i];
        end
        for (int i = 0; i < n_data; i++) begin
            dmem[gold[DATA_BASE+2*i][9:2]] <= gold[DATA_BASE+2*i+1];
        end
    end

    // Store port with memory update and checks
    always @(posedge clk) begin
        if (!rst && mem_wr) begin
            dmem[mem_addr[9:2]] <= mem_wr_data;
            if (st_idx >= n_st) begin
                $display("Unexpected store to %h after the expected list ended", mem_addr);
                errors++;
            end else begin
                assert (mem_addr == gold[STORE_BASE+2*st_idx] &&
                        mem_wr_data == gold[STORE_BASE+2*st_idx+1])
                else begin
                    $display("CHECK FAILED store[%0d]: expected %h <= %h actual %h <= %h",
                             st_idx, gold[STORE_BASE+2*st_idx],
                             gold[STORE_BASE+2*st_idx+1], mem_addr, mem_wr_data);
                    errors++;
                end
                st_idx++;
            end
        end
    end

    // Retire port and reset state
    always @(posedge clk) begin
        cyc++;
        if (rst) begin
            if (cyc > 1) begin
                assert (!reg_wr && !mem_wr)
                else begin
                    $display("Write strobe seen while reset is held");
                    errors++;
                end
            end
        end else if (reg_wr) begin
            if (ret_idx >= n_ret) begin
                $display("Unexpected retire of r%0d after the expected list ended", rd);
                errors++;
            end else begin
                assert (rd == gold[RETIRE_BASE+2*ret_idx][4:0] &&
                        reg_wr_data == gold[RETIRE_BASE+2*ret_idx+1])
                else begin
                    $display("CHECK FAILED retire[%0d]: expected r%0d=%h actual r%0d=%h",
                             ret_idx, gold[RETIRE_BASE+2*ret_idx][4:0],
                             gold[RETIRE_BASE+2*ret_idx+1], rd, reg_wr_data);
                    errors++;
                end
                ret_idx++;
            end
        end
    end

    initial begin
        rst     <= 1'b1;
        init_pc <= '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (i_addr == init_pc)
        else begin
            $display("CHECK FAILED reset_pc: expected %h actual %h", init_pc, i_addr);
            errors++;
        end
        while (ret_idx < n_ret || st_idx < n_st) begin
            @(posedge clk);
        end
        // Extra cycles catch writes from discarded instructions
        repeat (20) @(posedge clk);
        $display("Errors: %0d, retired %0d of %0d, stores %0d of %0d",
                 errors, ret_idx, n_ret, st_idx, n_st);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog of 20 cycles per program word plus margin
    initial begin
        #1;
        repeat (20 * n_prog + 100) @(posedge clk);
        $display("Timeout: retire or store list did not finish");
        $display("Errors: %0d, retired %0d of %0d, stores %0d of %0d",
                 errors, ret_idx, n_ret, st_idx, n_st);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- list.f
+incdir+include
verilog/dlx_pkg.sv
verilog/dlx_decode.sv
verilog/dlx_hazard.sv
verilog/dlx_execute.sv
verilog/dlx_regfile.sv
verilog/dlx_pipeline.sv
verilog/dlx_core.sv
testbench/dlx_core_chk.sv
testbench/dlx_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the DLX core testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f list.f --top-module dlx_core_tb -o dlx_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/dlx_core_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation executable returned status $run_status"
    exit 1
fi

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0

//--- testbench/dlx_core_golden.txt
// Word 0..3: program words, data entries, retire entries, store entries
// @10 program, @50 data (byte addr, value), @70 retire (rd, value), @B0 store (addr, data)
@00
0000001E 00000001 00000010 00000003
@10
20010005 20220003 00221820 00612022 00822824 00A13025 00C33826 00E4402A
00014822 0128502A AC030010 8C0B0010 01616020 8C0D0020 AC0D0024 10E0000C
20140001 AC010030 20150002 14E00008 200E0007 20000009 000E7820 0800000C
20160003 AC020034 20170004 21F00001 AC100038 0BFFFFFC
@50
00000020 12345678
// Retire list in program order
@70
00000001 00000005 00000002 00000008 00000003 0000000D 00000004 00000008
00000005 00000008 00000006 0000000D 00000007 00000000 00000008 00000001
00000009 FFFFFFFB 0000000A 00000001 0000000B 0000000D 0000000C 00000012
0000000D 12345678 0000000E 00000007 0000000F 00000007 00000010 00000008
// Store list in program order
@B0
00000010 0000000D 00000024 12345678 00000038 00000008
